// ==== compile.f ====
schedPkg.sv
popCount.sv
dispatchDecode.sv
issueQueue.sv
writebackSchedule.sv
schedTop.sv
tbSched.sv

// ==== Bender.yml ====
package:
  name: sched

sources:
  - schedPkg.sv
  - popCount.sv
  - dispatchDecode.sv
  - issueQueue.sv
  - writebackSchedule.sv
  - schedTop.sv
  - target: simulation
    files:
      - tbSched.sv

// ==== tbSched.sv ====
`timescale 1ns/1ps

module tbSched import schedPkg::*; ();

  localparam int QueueDepth    = 16;
  localparam int DispatchWidth = 3;
  localparam int RandomGroups  = 40;
  localparam int DrainLimit    = 200;
  // Reset, five directed tests, the random groups at a few cycles each, and a margin.
  localparam int CycleLimit    = 4 + 10 + 30 + 30 + 80 + 40 + RandomGroups * 10 + 100;

  typedef dispatchOpT [DispatchWidth-1:0] groupT;

  logic                  clk;
  logic                  rstN;
  groupT                 dispatchGroup;
  logic                  dispatchStall;
  logic                  issueEnable;
  completeT              complete;
  logic [QueueDepth:0]   freeCount;

  string                 testName;
  int                    errorCount;
  int                    checkCount;
  int                    cycleCount = 0;
  logic [31:0]           lfsr;
  groupT                 srcGroup;
  logic                  srcEnable;
  logic                  randomEnable;
  logic                  lastCaptured;
  logic [QueueDepth:0]   seenFree;
  logic                  seenStall;
  int                    seenTags [$];
  int                    pending [64];  // Ops per tag dispatched but not yet completed.

  // Reference model state.
  logic                  mBusy   [QueueDepth];
  logic                  mIssued [QueueDepth];
  int                    mClass  [QueueDepth];
  int                    mTag    [QueueDepth];
  int                    mRemain [QueueDepth];  // Edges left until completion.
  groupT                 mDecoded;
  int                    mDecCount;
  logic                  mCompValid;
  int                    mCompTag;
  logic                  mStall;
  int                    mFree;

  schedTop #(
    .QueueDepth   (QueueDepth),
    .DispatchWidth(DispatchWidth)
  ) u_dut (
    .clk          (clk),
    .rstN         (rstN),
    .dispatchGroup(dispatchGroup),
    .dispatchStall(dispatchStall),
    .issueEnable  (issueEnable),
    .complete     (complete),
    .freeCount    (freeCount)
  );

  initial
    clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount > CycleLimit)
    begin
      $display("Timeout: the run did not finish within %0d cycles.", CycleLimit);
      $display("tests failed");
      $finish;
    end
  end

  function automatic int latencyOf(input int cls);
    return (cls == OpLoad) ? 3 : (cls == OpStore) ? 2 : 1;
  endfunction

  function automatic logic [31:0] randomBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic dispatchOpT makeOp(input logic valid, input opClassE cls, input int tag);
    dispatchOpT op;
    op.valid   = valid;
    op.opClass = cls;
    op.destTag = tagT'(tag);
    return op;
  endfunction

  function automatic groupT fullGroup(input int tag);
    groupT grp;
    for (int i = 0; i < DispatchWidth; i++)
      grp[i] = makeOp(1'b1, OpAlu, (tag + i) % 64);
    return grp;
  endfunction

  function automatic logic entryFree(input int e);
    return !mBusy[e] || mRemain[e] == 1;  // A completing entry counts as free.
  endfunction

  function automatic logic modelIdle();
    logic idle;
    idle = (mDecCount == 0) && !mCompValid;
    for (int e = 0; e < QueueDepth; e++)
      idle = idle && !mBusy[e];
    return idle;
  endfunction

  task automatic checkValue(input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
    checkCount++;
    if (expected !== actual)
    begin
      errorCount++;
      $display("FAILED %s %s: expected %0h, actual %0h", testName, what, expected, actual);
    end
  endtask

  task automatic resetModel();
    for (int e = 0; e < QueueDepth; e++)
    begin
      mBusy[e]   = 1'b0;
      mIssued[e] = 1'b0;
      mClass[e]  = 0;
      mTag[e]    = 0;
      mRemain[e] = 0;
    end
    for (int t = 0; t < 64; t++)
      pending[t] = 0;
    mDecoded   = '0;
    mDecCount  = 0;
    mCompValid = 1'b0;
    mCompTag   = 0;
  endtask

  task automatic evalModel();
    mFree = 0;
    for (int e = 0; e < QueueDepth; e++)
      if (entryFree(e))
        mFree++;
    mStall = mDecCount > mFree;  // The whole group must fit.
  endtask

  task automatic checkOutputs();
    evalModel();
    seenFree  = freeCount;
    seenStall = dispatchStall;
    checkValue("dispatchStall", 64'(mStall), 64'(dispatchStall));
    checkValue("freeCount", 64'(1) << mFree, 64'(freeCount));
    checkValue("complete.valid", 64'(mCompValid), 64'(complete.valid));
    if (complete.valid)
    begin
      checkValue("complete.destTag", 64'(mCompTag), 64'(complete.destTag));
      seenTags.push_back(int'(complete.destTag));
      if (pending[complete.destTag] == 0)
      begin
        errorCount++;
        $display("Error in %s: tag %0d completed with no op outstanding.",
                 testName, complete.destTag);
      end
      else
        pending[complete.destTag]--;
    end
  endtask

  task automatic advanceModel(input logic en, input groupT grp);
    logic freeNow [QueueDepth];
    logic stallNow;
    logic blocked;
    int   pick;
    int   lat;
    int   slot;
    evalModel();
    stallNow = mStall;
    pick     = -1;
    for (int e = 0; e < QueueDepth; e++)
      freeNow[e] = entryFree(e);
    for (int e = 0; e < QueueDepth; e++)
    begin
      if (pick < 0 && mBusy[e] && !mIssued[e])
      begin
        lat     = latencyOf(mClass[e]);
        blocked = 1'b0;
        for (int f = 0; f < QueueDepth; f++)
          if (mRemain[f] == lat + 1)
            blocked = 1'b1;  // Writeback cycle already taken.
        if (!blocked)
          pick = e;
      end
    end
    mCompValid = 1'b0;
    for (int e = 0; e < QueueDepth; e++)
    begin
      if (mBusy[e] && mIssued[e] && mRemain[e] == 1)
      begin
        mCompValid = 1'b1;
        mCompTag   = mTag[e];
        mBusy[e]   = 1'b0;
      end
      if (mRemain[e] > 0)
        mRemain[e]--;
    end
    if (en && pick >= 0)
    begin
      mIssued[pick] = 1'b1;
      mRemain[pick] = latencyOf(mClass[pick]);
    end
    if (!stallNow)
    begin
      slot = 0;
      for (int e = 0; e < QueueDepth; e++)
      begin
        if (freeNow[e] && slot < mDecCount)
        begin
          mBusy[e]   = 1'b1;
          mIssued[e] = 1'b0;
          mRemain[e] = 0;
          mClass[e]  = int'(mDecoded[slot].opClass);
          mTag[e]    = int'(mDecoded[slot].destTag);
          pending[mTag[e]]++;
          slot++;
        end
      end
      mDecoded  = '0;
      mDecCount = 0;
      for (int i = 0; i < DispatchWidth; i++)
      begin
        if (grp[i].valid)
        begin
          mDecoded[mDecCount] = grp[i];
          mDecCount++;
        end
      end
    end
  endtask

  // Check at the falling edge, drive, then step the model at the rising edge.
  task automatic runCycle();
    logic en;
    @(negedge clk);
    checkOutputs();
    en = randomEnable ? (randomBits(1) != 0) : srcEnable;
    dispatchGroup = srcGroup;
    issueEnable   = en;
    lastCaptured  = !mStall;
    @(posedge clk);
    advanceModel(en, srcGroup);
  endtask

  task automatic sendGroup(input groupT grp);
    srcGroup = grp;
    runCycle();
    while (!lastCaptured)
      runCycle();
    srcGroup = '0;
  endtask

  task automatic drain();
    int n;
    int total;
    n            = 0;
    total        = 0;
    srcGroup     = '0;
    srcEnable    = 1'b1;
    randomEnable = 1'b0;
    while (!modelIdle() && n < DrainLimit)
    begin
      runCycle();
      n++;
    end
    if (!modelIdle())
    begin
      errorCount++;
      $display("Error in %s: the queue did not drain within %0d cycles.", testName, DrainLimit);
    end
    runCycle();
    checkValue("freeCount after drain", 64'(1) << QueueDepth, 64'(seenFree));
    for (int t = 0; t < 64; t++)
      total += pending[t];
    checkValue("ops still outstanding", 0, 64'(total));
  endtask

  task automatic testReset();
    testName  = "reset";
    srcEnable = 1'b0;
    seenTags.delete();
    runCycle();
    checkValue("dispatchStall", 0, 64'(seenStall));
    checkValue("completions", 0, 64'(seenTags.size()));
    checkValue("freeCount", 64'(1) << QueueDepth, 64'(seenFree));
  endtask

  task automatic testSingleAlu();
    groupT grp;
    int    n;
    testName  = "singleAlu";
    srcEnable = 1'b1;
    seenTags.delete();
    grp    = '0;
    grp[0] = makeOp(1'b1, OpAlu, 5);
    sendGroup(grp);
    n = 0;
    while (seenTags.size() == 0 && n < 20)
    begin
      runCycle();
      n++;
    end
    // Decode, allocate, issue, then the latency.
    checkValue("cycles to completion", 64'(3 + latencyOf(OpAlu)), 64'(n));
    drain();
  endtask

  task automatic testCompaction();
    groupT grp;
    testName  = "compaction";
    srcEnable = 1'b0;
    seenTags.delete();
    grp    = '0;
    grp[0] = makeOp(1'b1, OpAlu, 10);
    grp[2] = makeOp(1'b1, OpStore, 11);
    sendGroup(grp);
    runCycle();
    runCycle();
    checkValue("free entries", 64'(1) << (QueueDepth - 2), 64'(seenFree));
    drain();
    checkValue("completions", 2, 64'(seenTags.size()));
  endtask

  task automatic testFillStall();
    int captured;
    int stalledCycles;
    int tries;
    int tag;
    testName      = "fillStall";
    srcEnable     = 1'b0;
    captured      = 0;
    stalledCycles = 0;
    tries         = 0;
    tag           = 32;
    seenTags.delete();
    srcGroup = fullGroup(tag);
    while (stalledCycles < 4 && tries < 40)
    begin
      runCycle();
      tries++;
      if (seenStall)
        stalledCycles++;
      if (lastCaptured)
      begin
        captured++;
        tag      = tag + DispatchWidth;
        srcGroup = fullGroup(tag);
      end
    end
    checkValue("groups before stall", 64'(QueueDepth / DispatchWidth + 1), 64'(captured));
    srcEnable = 1'b1;
    tries     = 0;
    while (!lastCaptured && tries < 60)
    begin
      runCycle();
      tries++;
    end
    checkValue("held group admitted", 1, 64'(lastCaptured));
    drain();
    checkValue("completions", 64'((captured + 1) * DispatchWidth), 64'(seenTags.size()));
  endtask

  task automatic testMixed();
    groupT grp;
    testName  = "mixedLatency";
    srcEnable = 1'b1;
    seenTags.delete();
    grp[0] = makeOp(1'b1, OpLoad, 20);
    grp[1] = makeOp(1'b1, OpLoad, 21);
    grp[2] = makeOp(1'b1, OpAlu, 22);
    sendGroup(grp);
    grp[0] = makeOp(1'b1, OpAlu, 23);
    grp[1] = makeOp(1'b1, OpStore, 24);
    grp[2] = makeOp(1'b1, OpAlu, 25);
    sendGroup(grp);
    drain();
    checkValue("completions", 6, 64'(seenTags.size()));
  endtask

  task automatic testRandom();
    groupT grp;
    logic  v;
    int    cls;
    int    tag;
    int    dispatched;
    testName     = "randomGroups";
    randomEnable = 1'b1;
    dispatched   = 0;
    seenTags.delete();
    for (int g = 0; g < RandomGroups; g++)
    begin
      for (int i = 0; i < DispatchWidth; i++)
      begin
        v      = randomBits(1) != 0;
        cls    = int'(randomBits(2));
        tag    = int'(randomBits(6));
        grp[i] = makeOp(v, opClassE'(cls), tag);
        if (v)
          dispatched++;
      end
      sendGroup(grp);
    end
    drain();
    checkValue("completions", 64'(dispatched), 64'(seenTags.size()));
  endtask

  initial
  begin
    lfsr          = 32'd91347;
    rstN          = 1'b0;
    dispatchGroup = '0;
    issueEnable   = 1'b0;
    srcGroup      = '0;
    srcEnable     = 1'b0;
    randomEnable  = 1'b0;
    lastCaptured  = 1'b0;
    errorCount    = 0;
    checkCount    = 0;
    resetModel();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    testReset();
    testSingleAlu();
    testCompaction();
    testFillStall();
    testMixed();
    testRandom();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== schedTop.sv ====
`timescale 1ns/1ps

module schedTop import schedPkg::*; #(
  parameter int QueueDepth    = 16,
  parameter int DispatchWidth = 3
) (
  input  logic                           clk,
  input  logic                           rstN,
  input  dispatchOpT [DispatchWidth-1:0] dispatchGroup,
  output logic                           dispatchStall,
  input  logic                           issueEnable,
  output completeT                       complete,
  output logic       [QueueDepth:0]      freeCount
);

  localparam int EntryWidth = $clog2(QueueDepth);

  dispatchOpT [DispatchWidth-1:0] decodedGroup;
  logic       [DispatchWidth:0]   groupCount;
  logic                           stall;
  logic                           issueValid;
  tagT                            issueTag;
  logic       [EntryWidth-1:0]    issueEntry;
  latencyT                        issueLatency;
  logic       [MaxLatency-1:0]    reserved;
  logic                           freeValid;
  logic       [EntryWidth-1:0]    freeEntry;

  assign dispatchStall = stall;

  dispatchDecode #(
    .DispatchWidth(DispatchWidth)
  ) u_decode (
    .clk          (clk),
    .rstN         (rstN),
    .dispatchGroup(dispatchGroup),
    .stall        (stall),
    .decodedGroup (decodedGroup),
    .groupCount   (groupCount)
  );

  issueQueue #(
    .QueueDepth   (QueueDepth),
    .DispatchWidth(DispatchWidth)
  ) u_queue (
    .clk         (clk),
    .rstN        (rstN),
    .decodedGroup(decodedGroup),
    .groupCount  (groupCount),
    .issueEnable (issueEnable),
    .reserved    (reserved),
    .freeValid   (freeValid),
    .freeEntry   (freeEntry),
    .stall       (stall),
    .issueValid  (issueValid),
    .issueTag    (issueTag),
    .issueEntry  (issueEntry),
    .issueLatency(issueLatency),
    .freeCount   (freeCount)
  );

  writebackSchedule #(
    .QueueDepth(QueueDepth)
  ) u_writeback (
    .clk         (clk),
    .rstN        (rstN),
    .issueValid  (issueValid),
    .issueTag    (issueTag),
    .issueEntry  (issueEntry),
    .issueLatency(issueLatency),
    .reserved    (reserved),
    .complete    (complete),
    .freeValid   (freeValid),
    .freeEntry   (freeEntry)
  );

endmodule

// ==== writebackSchedule.sv ====
`timescale 1ns/1ps

module writebackSchedule import schedPkg::*; #(
  parameter int QueueDepth = 16
) (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          issueValid,
  input  tagT                           issueTag,
  input  logic [$clog2(QueueDepth)-1:0] issueEntry,
  input  latencyT                       issueLatency,
  output logic [MaxLatency-1:0]         reserved,
  output completeT                      complete,
  output logic                          freeValid,
  output logic [$clog2(QueueDepth)-1:0] freeEntry
);

  localparam int EntryWidth = $clog2(QueueDepth);

  typedef struct packed {
    logic                  valid;
    tagT                   tag;
    logic [EntryWidth-1:0] entry;
  } slotT;

  slotT [MaxLatency-1:0] sched;
  slotT [MaxLatency-1:0] shifted;
  slotT [MaxLatency-1:0] nextSched;

  // Everything moves one slot toward the head each cycle.
  always_comb
  begin
    for (int i = 0; i < MaxLatency - 1; i++)
      shifted[i] = sched[i+1];
    shifted[MaxLatency-1] = '0;
  end

  always_comb
  begin
    nextSched = shifted;
    if (issueValid)
      nextSched[issueLatency - 1'b1] = '{valid: 1'b1, tag: issueTag, entry: issueEntry};
  end

  // Bit i is taken when slot i would be filled by a shift at the next edge.
  always_comb
  begin
    for (int i = 0; i < MaxLatency; i++)
      reserved[i] = shifted[i].valid;
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      sched    <= '0;
      complete <= '0;
    end
    else
    begin
      sched    <= nextSched;
      complete <= '{valid: sched[0].valid, destTag: sched[0].tag};
    end
  end

  assign freeValid = sched[0].valid;  // Frees at the edge that raises complete.
  assign freeEntry = sched[0].entry;

  noSlotCollision: assert property (@(posedge clk) disable iff (!rstN)
    issueValid |-> !shifted[issueLatency - 1'b1].valid);

endmodule

// ==== issueQueue.sv ====
`timescale 1ns/1ps

module issueQueue import schedPkg::*; #(
  parameter int QueueDepth    = 16,
  parameter int DispatchWidth = 3
) (
  input  logic                                   clk,
  input  logic                                   rstN,
  input  dispatchOpT [DispatchWidth-1:0]         decodedGroup,
  input  logic       [DispatchWidth:0]           groupCount,
  input  logic                                   issueEnable,
  input  logic       [MaxLatency-1:0]            reserved,
  input  logic                                   freeValid,
  input  logic       [$clog2(QueueDepth)-1:0]    freeEntry,
  output logic                                   stall,
  output logic                                   issueValid,
  output tagT                                    issueTag,
  output logic       [$clog2(QueueDepth)-1:0]    issueEntry,
  output latencyT                                issueLatency,
  output logic       [QueueDepth:0]              freeCount
);

  localparam int EntryWidth = $clog2(QueueDepth);
  localparam int SlotWidth  = (DispatchWidth > 1) ? $clog2(DispatchWidth) : 1;

  logic    [QueueDepth-1:0] busy;
  logic    [QueueDepth-1:0] issued;
  opClassE                  entryClass [QueueDepth];
  tagT                      entryTag   [QueueDepth];

  logic    [QueueDepth-1:0] freeMask;
  logic    [QueueDepth-1:0] atLeast;
  logic    [QueueDepth-1:0] writeEn;
  logic    [SlotWidth-1:0]  writeSlot  [QueueDepth];
  logic    [QueueDepth-1:0] eligible;
  logic                     anyEligible;

  // An entry freed by this cycle's completion can take a new op at the same edge.
  assign freeMask = ~busy | (QueueDepth'(freeValid) << freeEntry);

  popCountAtLeast #(
    .Width(QueueDepth)
  ) u_freeAtLeast (
    .bits(freeMask),
    .cnt (atLeast)
  );

  popCountOneHot #(
    .Width(QueueDepth)
  ) u_freeCount (
    .bits(freeMask),
    .cnt (freeCount)
  );

  // Group of n ops needs at least n free entries.
  assign stall = |(groupCount[DispatchWidth:1] & ~atLeast[DispatchWidth-1:0]);

  // Slot s goes to the s-th lowest free entry.
  always_comb
  begin
    int unsigned slot;
    slot = 0;
    writeEn = '0;
    for (int e = 0; e < QueueDepth; e++)
    begin
      writeSlot[e] = '0;
      if (freeMask[e] && slot < DispatchWidth)
      begin
        writeEn[e]   = decodedGroup[slot].valid && !stall;
        writeSlot[e] = SlotWidth'(slot);
        slot++;
      end
    end
  end

  // Waiting entries whose writeback slot is still open.
  always_comb
  begin
    for (int e = 0; e < QueueDepth; e++)
      eligible[e] = busy[e] && !issued[e] &&
                    !reserved[classLatency(entryClass[e]) - 1'b1];
  end

  always_comb
  begin
    anyEligible = 1'b0;
    issueEntry  = '0;
    for (int e = QueueDepth - 1; e >= 0; e--)
    begin
      if (eligible[e])
      begin
        anyEligible = 1'b1;
        issueEntry  = EntryWidth'(e);
      end
    end
  end

  assign issueValid   = anyEligible && issueEnable;
  assign issueTag     = entryTag[issueEntry];
  assign issueLatency = classLatency(entryClass[issueEntry]);

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      busy   <= '0;
      issued <= '0;
    end
    else
    begin
      if (freeValid)
        busy[freeEntry] <= 1'b0;
      if (issueValid)
        issued[issueEntry] <= 1'b1;
      for (int e = 0; e < QueueDepth; e++)
      begin
        if (writeEn[e])
        begin
          busy[e]   <= 1'b1;  // Overrides a free of the same entry.
          issued[e] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int e = 0; e < QueueDepth; e++)
    begin
      if (writeEn[e])
      begin
        entryClass[e] <= decodedGroup[writeSlot[e]].opClass;
        entryTag[e]   <= decodedGroup[writeSlot[e]].destTag;
      end
    end
  end

  freeOfIssued: assert property (@(posedge clk) disable iff (!rstN)
    freeValid |-> busy[freeEntry] && issued[freeEntry]);

endmodule

// ==== dispatchDecode.sv ====
`timescale 1ns/1ps

module dispatchDecode import schedPkg::*; #(
  parameter int DispatchWidth = 3
) (
  input  logic                           clk,
  input  logic                           rstN,
  input  dispatchOpT [DispatchWidth-1:0] dispatchGroup,
  input  logic                           stall,
  output dispatchOpT [DispatchWidth-1:0] decodedGroup,
  output logic       [DispatchWidth:0]   groupCount
);

  dispatchOpT [DispatchWidth-1:0] packedGroup;
  logic       [DispatchWidth-1:0] validBits;
  logic       [DispatchWidth:0]   nextCount;

  always_comb
  begin
    for (int i = 0; i < DispatchWidth; i++)
      validBits[i] = dispatchGroup[i].valid;
  end

  // Move the valid ops down to the low slots, keeping their order.
  always_comb
  begin
    int unsigned slot;
    slot = 0;
    packedGroup = '0;
    for (int i = 0; i < DispatchWidth; i++)
    begin
      if (dispatchGroup[i].valid)
      begin
        packedGroup[slot] = dispatchGroup[i];
        slot++;
      end
    end
  end

  popCountOneHot #(
    .Width(DispatchWidth)
  ) u_groupCount (
    .bits(validBits),
    .cnt (nextCount)
  );

  // The source holds its group while stalled, so the register just waits.
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      decodedGroup <= '0;
      groupCount   <= {{DispatchWidth{1'b0}}, 1'b1};  // Zero ops.
    end
    else if (!stall)
    begin
      decodedGroup <= packedGroup;
      groupCount   <= nextCount;
    end
  end

  groupCountOneHot: assert property (@(posedge clk) disable iff (!rstN)
    $onehot(groupCount));

endmodule

// ==== popCount.sv ====
`timescale 1ns/1ps

// One-hot population count. Bit k of cnt is set when bits holds exactly k ones.
module popCountOneHot #(
  parameter int Width = 16
) (
  input  logic [Width-1:0] bits,
  output logic [Width:0]   cnt
);

  // Start at zero ones and move the single set bit up once per input one.
  always_comb
  begin
    cnt = {{Width{1'b0}}, 1'b1};
    for (int i = 0; i < Width; i++)
    begin
      if (bits[i])
        cnt = {cnt[Width-1:0], 1'b0};
    end
  end

endmodule


// Thermometer count. Bit k-1 of cnt is set when bits holds at least k ones.
module popCountAtLeast #(
  parameter int Width = 16
) (
  input  logic [Width-1:0] bits,
  output logic [Width-1:0] cnt
);

  // Every input one fills one more bit from the bottom.
  always_comb
  begin
    cnt = '0;
    for (int i = 0; i < Width; i++)
    begin
      if (bits[i])
        cnt = (cnt << 1) | Width'(1);
    end
  end

endmodule

// ==== schedPkg.sv ====
package schedPkg;

  // Operation class of a micro-op. It selects the writeback latency.
  typedef enum logic [1:0] {
    OpAlu    = 2'd0,
    OpBranch = 2'd1,
    OpStore  = 2'd2,
    OpLoad   = 2'd3
  } opClassE;

  typedef logic [5:0] tagT;  // Destination tag.

  // Longest writeback latency. It sets the depth of the writeback schedule.
  localparam int MaxLatency = 3;
  localparam int LatencyWidth = $clog2(MaxLatency + 1);

  typedef logic [LatencyWidth-1:0] latencyT;

  // One slot of a dispatch group.
  typedef struct packed {
    logic    valid;
    opClassE opClass;
    tagT     destTag;
  } dispatchOpT;

  // Completion reported on the single writeback port.
  typedef struct packed {
    logic valid;
    tagT  destTag;
  } completeT;

  // Fixed latency per class, counted from the issue edge to the completion edge.
  function automatic latencyT classLatency(opClassE opClass);
    latencyT lat;
    case (opClass)
      OpAlu:
        lat = latencyT'(1);
      OpBranch:
        lat = latencyT'(1);
      OpStore:
        lat = latencyT'(2);
      OpLoad:
        lat = latencyT'(3);
      default:
        lat = latencyT'(MaxLatency);
    endcase
    return lat;
  endfunction

endpackage
